// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_wb_interconnect
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_wb_interconnect.sv
// testbench: clock, reset, lfsr stimulus, slave models, assertions, watchdog and report
`timescale 1ns/1ps

module tb_wb_interconnect;
  import wb_ic_pkg::*;

  // ------------------------------
  // transaction budget per phase
  localparam int ROUTE_TXN = 24;
  localparam int NONE_TXN  = 3;
  localparam int REMAP_TXN = 3;
  localparam int RR_TXN    = 12;
  localparam int N_TXN     = ROUTE_TXN + NONE_TXN + REMAP_TXN + RR_TXN;
  localparam int RR_EACH   = RR_TXN / 3;
  localparam int WD_CYC    = N_TXN * 40 + 200;
  // read data keys, one per slave model
  localparam logic [31:0] KEY_MEM  = 32'hC0DE_0000;
  localparam logic [31:0] KEY_UART = 32'h0000_5A5A;
  localparam logic [31:0] KEY_SRAM = 32'h00FF_0F00;

  logic clk = 1'b0;
  logic rst_n;
  logic [3:0] boot_remap;

  // master drive side, index = master number
  logic [2:0][31:0] m_dat;
  logic [2:0][31:0] m_adr;
  logic [2:0][3:0]  m_sel;
  logic [2:0]       m_we;
  logic [2:0]       m_cyc;
  logic [2:0]       m_stb;
  wire  [2:0][31:0] m_rdat;
  wire  [2:0]       m_ack;
  wire  [2:0]       m_err;

  // slave side, index = target id
  wire  [2:0][31:0] slv_dat;
  wire  [2:0][31:0] slv_adr;
  wire  [2:0][3:0]  slv_sel;
  wire  [2:0]       slv_we;
  wire  [2:0]       slv_cyc;
  wire  [2:0]       slv_stb;
  wire  [2:0][31:0] slv_rdat;
  wire  [7:0]       s1_adr;
  wire  [12:0]      s2_adr;
  logic [2:0]       s_ack  = '0;
  logic [2:0]       s_pend = '0;
  logic [2:0][1:0]  s_wait = '0;

  // expected transfer per master
  logic [2:0]       act;
  target_e          exp_tgt [3];
  logic [2:0][31:0] exp_adr;
  logic [2:0][31:0] exp_dat;
  logic [2:0][31:0] exp_rdat;
  logic [2:0][3:0]  exp_sel;
  logic [2:0]       exp_we;
  logic [2:0]       s_match;

  // round robin bookkeeping, seen[j][k] = k done while j waits
  logic             rr_on;
  int               last_done;
  logic [2:0][2:0]  seen;

  logic [15:0] lfsr_q = 16'd47864;
  int          errors = 0;
  int          cyc_cnt = 0;

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  wb_interconnect i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .boot_remap_i (boot_remap),
    .m0_dat_i (m_dat[0]), .m0_adr_i (m_adr[0]), .m0_sel_i (m_sel[0]),
    .m0_we_i  (m_we[0]),  .m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]),
    .m0_dat_o (m_rdat[0]), .m0_ack_o (m_ack[0]), .m0_err_o (m_err[0]),
    .m1_dat_i (m_dat[1]), .m1_adr_i (m_adr[1]), .m1_sel_i (m_sel[1]),
    .m1_we_i  (m_we[1]),  .m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]),
    .m1_dat_o (m_rdat[1]), .m1_ack_o (m_ack[1]), .m1_err_o (m_err[1]),
    .m2_dat_i (m_dat[2]), .m2_adr_i (m_adr[2]), .m2_sel_i (m_sel[2]),
    .m2_we_i  (m_we[2]),  .m2_cyc_i (m_cyc[2]), .m2_stb_i (m_stb[2]),
    .m2_dat_o (m_rdat[2]), .m2_ack_o (m_ack[2]), .m2_err_o (m_err[2]),
    .s0_dat_o (slv_dat[0]), .s0_adr_o (slv_adr[0]), .s0_sel_o (slv_sel[0]),
    .s0_we_o  (slv_we[0]),  .s0_cyc_o (slv_cyc[0]), .s0_stb_o (slv_stb[0]),
    .s0_dat_i (slv_rdat[0]), .s0_ack_i (s_ack[0]),
    .s1_dat_o (slv_dat[1]), .s1_adr_o (s1_adr),     .s1_sel_o (slv_sel[1]),
    .s1_we_o  (slv_we[1]),  .s1_cyc_o (slv_cyc[1]), .s1_stb_o (slv_stb[1]),
    .s1_dat_i (slv_rdat[1]), .s1_ack_i (s_ack[1]),
    .s2_dat_o (slv_dat[2]), .s2_adr_o (s2_adr),     .s2_sel_o (slv_sel[2]),
    .s2_we_o  (slv_we[2]),  .s2_cyc_o (slv_cyc[2]), .s2_stb_o (slv_stb[2]),
    .s2_dat_i (slv_rdat[2]), .s2_ack_i (s_ack[2])
  );

  // narrow slave addresses seen as 32 bits
  assign slv_adr[1] = {24'h0, s1_adr};
  assign slv_adr[2] = {19'h0, s2_adr};

  // slave read data = narrowed address xor slave key
  assign slv_rdat[0] = slv_adr[0] ^ KEY_MEM;
  assign slv_rdat[1] = slv_adr[1] ^ KEY_UART;
  assign slv_rdat[2] = slv_adr[2] ^ KEY_SRAM;

  // ------------------------------
  // helpers
  function automatic logic step_lfsr();
    logic fb;
    // taps 16 14 13 11
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], step_lfsr()};
    end
    return v;
  endfunction

  // region 0 flash, 1 spi registers, 2 uart, 3 sram
  function automatic logic [31:0] region_base(input int r);
    case (r)
      0:       return 32'h0040_0000;
      1:       return 32'h1000_0000;
      2:       return 32'h1001_0000;
      default: return 32'h1003_0000;
    endcase
  endfunction

  function automatic target_e region_tgt(input int r);
    case (r)
      0, 1:    return TGT_MEM;
      2:       return TGT_UART;
      default: return TGT_SRAM;
    endcase
  endfunction

  // word aligned, then cut to the slave's address width
  function automatic logic [31:0] narrow_adr(input logic [31:0] adr, input target_e tgt);
    logic [31:0] a;
    a = {adr[31:2], 2'b00};
    case (tgt)
      TGT_UART: a = a & 32'h0000_00FF;
      TGT_SRAM: a = a & 32'h0000_1FFF;
      default:  a = a;
    endcase
    return a;
  endfunction

  function automatic logic [31:0] slave_key(input target_e tgt);
    case (tgt)
      TGT_MEM:  return KEY_MEM;
      TGT_UART: return KEY_UART;
      default:  return KEY_SRAM;
    endcase
  endfunction

  task automatic log_failure(input string msg);
    errors++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  // completion order under contention
  task automatic note_done(input logic [1:0] mi);
    int rr_next;
    if (rr_on) begin
      if (last_done >= 0) begin
        rr_next = (last_done + 1) % 3;
        assert (int'(mi) == rr_next)
          else log_failure($sformatf("m%0d completed, m%0d was next", mi, rr_next));
      end
      for (int j = 0; j < 3; j++) begin
        if (j != int'(mi) && act[j]) begin
          assert (!seen[j][mi])
            else log_failure($sformatf("m%0d completed twice while m%0d waits", mi, j));
          seen[j][mi] = 1'b1;
        end
      end
      last_done = int'(mi);
    end
    seen[mi] = '0;
  endtask

  // one classic cycle, held until ack or err
  task automatic run_txn(input logic [1:0] mi, input logic [31:0] adr, input logic we,
                         input target_e tgt);
    logic [31:0] dat;
    logic [3:0]  sel;
    dat = rand_bits(32);
    sel = 4'(rand_bits(4));
    @(posedge clk);
    #1;
    exp_tgt[mi]  = tgt;
    exp_adr[mi]  = narrow_adr(adr, tgt);
    exp_rdat[mi] = narrow_adr(adr, tgt) ^ slave_key(tgt);
    exp_dat[mi]  = dat;
    exp_sel[mi]  = sel;
    exp_we[mi]   = we;
    seen[mi]     = '0;
    m_adr[mi] = adr;
    m_dat[mi] = dat;
    m_sel[mi] = sel;
    m_we[mi]  = we;
    m_cyc[mi] = 1'b1;
    m_stb[mi] = 1'b1;
    act[mi]   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!(m_ack[mi] || m_err[mi]));
    note_done(mi);
    // drop stb in the cycle after the response
    @(posedge clk);
    #1;
    m_stb[mi] = 1'b0;
    m_cyc[mi] = 1'b0;
    act[mi]   = 1'b0;
  endtask

  task automatic rr_burst(input logic [1:0] mi);
    int r;
    logic [31:0] adr;
    repeat (RR_EACH) begin
      r   = int'(rand_bits(2));
      adr = region_base(r) + rand_bits(12);
      run_txn(mi, adr, 1'(rand_bits(1)), region_tgt(r));
    end
  endtask

  // ------------------------------
  // slave models, ack after 0..3 wait cycles
  initial begin : slave_models
    forever begin
      @(posedge clk);
      #1;
      for (int s = 0; s < 3; s++) begin
        if (s_ack[s]) begin
          s_ack[s] = 1'b0;
        end else if (slv_stb[s]) begin
          if (!s_pend[s]) begin
            s_pend[s] = 1'b1;
            s_wait[s] = 2'(rand_bits(2));
          end
          if (s_wait[s] == 2'd0) begin
            s_ack[s]  = 1'b1;
            s_pend[s] = 1'b0;
          end else begin
            s_wait[s] = s_wait[s] - 2'd1;
          end
        end
      end
    end
  end

  // a strobed slave must carry some waiting master's request
  always_comb begin
    for (int s = 0; s < 3; s++) begin
      s_match[s] = 1'b0;
      for (int k = 0; k < 3; k++) begin
        if (act[k] && exp_tgt[k] == target_e'(s) && slv_adr[s] == exp_adr[k] &&
            slv_dat[s] == exp_dat[k] && slv_sel[s] == exp_sel[k] &&
            slv_we[s] == exp_we[k]) begin
          s_match[s] = 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // checks
  for (genvar s = 0; s < 3; s++) begin : g_slv_chk
    a_route: assert property (@(posedge clk) disable iff (!rst_n)
      slv_stb[s] |-> slv_cyc[s] && s_match[s])
      else log_failure($sformatf("slave %0d strobed without a matching request", s));
  end

  a_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(slv_stb))
    else log_failure("more than one slave strobed");

  for (genvar k = 0; k < 3; k++) begin : g_mst_chk
    a_ack: assert property (@(posedge clk) disable iff (!rst_n)
      m_ack[k] |-> act[k] && !m_err[k] && exp_tgt[k] != TGT_NONE)
      else log_failure($sformatf("unexpected ack on m%0d", k));
    a_rdat: assert property (@(posedge clk) disable iff (!rst_n)
      (m_ack[k] && !exp_we[k]) |-> m_rdat[k] == exp_rdat[k])
      else log_failure($sformatf("m%0d read %h, expected %h", k, m_rdat[k], exp_rdat[k]));
    a_err: assert property (@(posedge clk) disable iff (!rst_n)
      m_err[k] |-> act[k] && exp_tgt[k] == TGT_NONE)
      else log_failure($sformatf("unexpected err on m%0d", k));
  end

  // reset cycles 2..8 and the first cycle after release
  a_reset_quiet: assert property (@(posedge clk)
    (cyc_cnt >= 1 && cyc_cnt <= 9) |->
      (slv_stb == '0 && slv_cyc == '0 && m_ack == '0 && m_err == '0))
    else log_failure("strobe or response active around reset");

  // ------------------------------
  // watchdog
  initial begin : watchdog
    repeat (WD_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, transfers never finished", WD_CYC);
    $display("TEST FAIL");
    $finish;
  end

  // main sequence
  initial begin : main
    logic [31:0] adr;
    rst_n      = 1'b0;
    boot_remap = '0;
    m_dat      = '0;
    m_adr      = '0;
    m_sel      = '0;
    m_we       = '0;
    m_cyc      = '0;
    m_stb      = '0;
    act        = '0;
    exp_adr    = '0;
    exp_dat    = '0;
    exp_rdat   = '0;
    exp_sel    = '0;
    exp_we     = '0;
    seen       = '0;
    rr_on      = 1'b0;
    last_done  = -1;
    for (int k = 0; k < 3; k++) begin
      exp_tgt[k] = TGT_NONE;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // write then read back each region from each master
    for (int m = 0; m < 3; m++) begin
      for (int r = 0; r < 4; r++) begin
        adr = region_base(r) + rand_bits(12);
        run_txn(2'(m), adr, 1'b1, region_tgt(r));
        run_txn(2'(m), adr, 1'b0, region_tgt(r));
      end
    end

    // unmapped space answers with err
    for (int m = 0; m < 3; m++) begin
      run_txn(2'(m), 32'h2000_0000, 1'(rand_bits(1)), TGT_NONE);
    end

    // boot window 1 at 0x800
    @(posedge clk);
    #1;
    boot_remap = 4'b0010;
    run_txn(2'd1, 32'h0000_0800, 1'b0, TGT_SRAM);
    run_txn(2'd0, 32'h0000_0800, 1'b0, TGT_MEM);
    @(posedge clk);
    #1;
    boot_remap = 4'b0000;
    run_txn(2'd1, 32'h0000_0800, 1'b0, TGT_MEM);

    // all three masters contend
    rr_on     = 1'b1;
    last_done = -1;
    fork
      rr_burst(2'd0);
      rr_burst(2'd1);
      rr_burst(2'd2);
    join
    rr_on = 1'b0;

    repeat (4) @(posedge clk);
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
src/wb_ic_pkg.sv
src/wb_req_if.sv
src/wb_addr_decode.sv
src/wb_rr_arbiter.sv
src/wb_master_mux.sv
src/wb_stage.sv
src/wb_slave_demux.sv
src/wb_interconnect.sv
bench/tb_wb_interconnect.sv

// File: src/wb_addr_decode.sv
// module: per-master address decode with optional boot remap to sram
`timescale 1ns/1ps

module wb_addr_decode #(
  parameter bit REMAP_EN = 1'b0,
  parameter int AW       = wb_ic_pkg::ADR_W,
  parameter int RW       = wb_ic_pkg::REMAP_W
) (
  input  logic [AW-1:0]      adr_i,
  input  logic [RW-1:0]      remap_i,
  output wb_ic_pkg::target_e tid_o
);
  import wb_ic_pkg::*;

  logic remap_hit;

  // window w covers w*2KB .. w*2KB+2KB-1, only when its remap bit is set
  always_comb begin
    remap_hit = 1'b0;
    for (int w = 0; w < RW; w++) begin
      if (remap_i[w] && (adr_i[AW-1:REMAP_SHIFT] == (AW-REMAP_SHIFT)'(w))) begin
        remap_hit = 1'b1;
      end
    end
  end

  // remap wins over the normal map
  always_comb begin
    if (REMAP_EN && remap_hit) begin
      tid_o = TGT_SRAM;
    end else if (adr_i[AW-1 -: 4] == MEM_TAG) begin
      tid_o = TGT_MEM;
    end else if (adr_i[AW-1 -: 16] == REG_TAG) begin
      // register block sits behind the flash controller
      tid_o = TGT_MEM;
    end else if (adr_i[AW-1 -: 16] == UART_TAG) begin
      tid_o = TGT_UART;
    end else if (adr_i[AW-1 -: 16] == SRAM_TAG) begin
      tid_o = TGT_SRAM;
    end else begin
      // unmapped, staging stage answers with err
      tid_o = TGT_NONE;
    end
  end

endmodule

// File: src/wb_ic_pkg.sv
// bus widths, target and arbiter enums, memory map tags, remap window size
package wb_ic_pkg;

  // ------------------------------
  // bus widths
  localparam int DATA_W   = 32;
  localparam int ADR_W    = 32;
  localparam int SEL_W    = 4;
  localparam int N_MST    = 3;
  // uart register window
  localparam int S1_ADR_W = 8;
  // 8 KB sram, four 2 KB banks
  localparam int S2_ADR_W = 13;
  localparam int REMAP_W  = 4;

  // ------------------------------
  // memory map tags
  // flash lives anywhere below 0x1000_0000, checked on the top nibble
  localparam logic [3:0]  MEM_TAG  = 4'h0;
  // spi controller registers, served by the flash target
  localparam logic [15:0] REG_TAG  = 16'h1000;
  localparam logic [15:0] UART_TAG = 16'h1001;
  localparam logic [15:0] SRAM_TAG = 16'h1003;
  // boot remap window 2 KB
  localparam int REMAP_SHIFT = 11;

  // target id carried with each request
  typedef enum logic [1:0] {
    TGT_MEM  = 2'd0,
    TGT_UART = 2'd1,
    TGT_SRAM = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

  // current bus owner
  typedef enum logic [1:0] {
    OWN_M0 = 2'd0,
    OWN_M1 = 2'd1,
    OWN_M2 = 2'd2
  } arb_state_e;

endpackage

// File: src/wb_interconnect.sv
// module: top level wishbone interconnect, three masters to three targets
`timescale 1ns/1ps

module wb_interconnect #(
  parameter int DW    = wb_ic_pkg::DATA_W,
  parameter int AW    = wb_ic_pkg::ADR_W,
  parameter int SW    = wb_ic_pkg::SEL_W,
  parameter int NM    = wb_ic_pkg::N_MST,
  parameter int RW    = wb_ic_pkg::REMAP_W,
  parameter int S1_AW = wb_ic_pkg::S1_ADR_W,
  parameter int S2_AW = wb_ic_pkg::S2_ADR_W
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // bit n sends 0x800*n .. +2KB to sram for m1 and m2
  input  logic [RW-1:0]    boot_remap_i,
  // m0 external host
  input  logic [DW-1:0]    m0_dat_i,
  input  logic [AW-1:0]    m0_adr_i,
  input  logic [SW-1:0]    m0_sel_i,
  input  logic             m0_we_i,
  input  logic             m0_cyc_i,
  input  logic             m0_stb_i,
  output logic [DW-1:0]    m0_dat_o,
  output logic             m0_ack_o,
  output logic             m0_err_o,
  // m1 instruction port
  input  logic [DW-1:0]    m1_dat_i,
  input  logic [AW-1:0]    m1_adr_i,
  input  logic [SW-1:0]    m1_sel_i,
  input  logic             m1_we_i,
  input  logic             m1_cyc_i,
  input  logic             m1_stb_i,
  output logic [DW-1:0]    m1_dat_o,
  output logic             m1_ack_o,
  output logic             m1_err_o,
  // m2 data port
  input  logic [DW-1:0]    m2_dat_i,
  input  logic [AW-1:0]    m2_adr_i,
  input  logic [SW-1:0]    m2_sel_i,
  input  logic             m2_we_i,
  input  logic             m2_cyc_i,
  input  logic             m2_stb_i,
  output logic [DW-1:0]    m2_dat_o,
  output logic             m2_ack_o,
  output logic             m2_err_o,
  // s0 spi flash and registers
  output logic [DW-1:0]    s0_dat_o,
  output logic [AW-1:0]    s0_adr_o,
  output logic [SW-1:0]    s0_sel_o,
  output logic             s0_we_o,
  output logic             s0_cyc_o,
  output logic             s0_stb_o,
  input  logic [DW-1:0]    s0_dat_i,
  input  logic             s0_ack_i,
  // s1 uart
  output logic [DW-1:0]    s1_dat_o,
  output logic [S1_AW-1:0] s1_adr_o,
  output logic [SW-1:0]    s1_sel_o,
  output logic             s1_we_o,
  output logic             s1_cyc_o,
  output logic             s1_stb_o,
  input  logic [DW-1:0]    s1_dat_i,
  input  logic             s1_ack_i,
  // s2 sram
  output logic [DW-1:0]    s2_dat_o,
  output logic [S2_AW-1:0] s2_adr_o,
  output logic [SW-1:0]    s2_sel_o,
  output logic             s2_we_o,
  output logic             s2_cyc_o,
  output logic             s2_stb_o,
  input  logic [DW-1:0]    s2_dat_i,
  input  logic             s2_ack_i
);
  import wb_ic_pkg::*;

  // master side gathered into arrays, index = master number
  logic [NM-1:0][DW-1:0] mst_dat;
  logic [NM-1:0][AW-1:0] mst_adr;
  logic [NM-1:0][SW-1:0] mst_sel;
  logic [NM-1:0]         mst_we;
  logic [NM-1:0]         mst_cyc;
  logic [NM-1:0]         mst_stb;
  target_e [NM-1:0]      mst_tid;
  logic [NM-1:0][DW-1:0] mst_rdat;
  logic [NM-1:0]         mst_ack;
  logic [NM-1:0]         mst_err;
  logic [NM-1:0]         arb_req;
  arb_state_e            gnt;
  logic                  stage_busy;

  wb_req_if #(.DW(DW), .AW(AW), .SW(SW)) m_bus ();
  wb_req_if #(.DW(DW), .AW(AW), .SW(SW)) s_bus ();

  assign mst_dat = {m2_dat_i, m1_dat_i, m0_dat_i};
  assign mst_adr = {m2_adr_i, m1_adr_i, m0_adr_i};
  assign mst_sel = {m2_sel_i, m1_sel_i, m0_sel_i};
  assign mst_we  = {m2_we_i, m1_we_i, m0_we_i};
  assign mst_cyc = {m2_cyc_i, m1_cyc_i, m0_cyc_i};
  assign mst_stb = {m2_stb_i, m1_stb_i, m0_stb_i};

  assign m0_dat_o = mst_rdat[0];
  assign m0_ack_o = mst_ack[0];
  assign m0_err_o = mst_err[0];
  assign m1_dat_o = mst_rdat[1];
  assign m1_ack_o = mst_ack[1];
  assign m1_err_o = mst_err[1];
  assign m2_dat_o = mst_rdat[2];
  assign m2_ack_o = mst_ack[2];
  assign m2_err_o = mst_err[2];

  // ------------------------------
  // decode, host m0 ignores boot remap
  for (genvar k = 0; k < NM; k++) begin : g_dec
    wb_addr_decode #(.REMAP_EN(k != 0), .AW(AW), .RW(RW)) u_dec (
      .adr_i   (mst_adr[k]),
      .remap_i (boot_remap_i),
      .tid_o   (mst_tid[k])
    );
  end

  // drop a request in its own ack or err cycle, stb is still up there
  assign arb_req = mst_stb & ~mst_ack & ~mst_err;

  wb_rr_arbiter #(.NM(NM)) u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (arb_req),
    .busy_i  (stage_busy),
    .gnt_o   (gnt)
  );

  wb_master_mux #(.NM(NM), .DW(DW), .AW(AW), .SW(SW)) u_mux (
    .dat_i  (mst_dat),
    .adr_i  (mst_adr),
    .sel_i  (mst_sel),
    .we_i   (mst_we),
    .cyc_i  (mst_cyc),
    .stb_i  (mst_stb),
    .tid_i  (mst_tid),
    .gnt_i  (gnt),
    .bus    (m_bus),
    .rdat_o (mst_rdat),
    .ack_o  (mst_ack),
    .err_o  (mst_err)
  );

  wb_stage #(.DW(DW), .AW(AW), .SW(SW)) u_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .m       (m_bus),
    .s       (s_bus),
    .busy_o  (stage_busy)
  );

  wb_slave_demux #(.DW(DW), .AW(AW), .SW(SW), .S1_AW(S1_AW), .S2_AW(S2_AW)) u_demux (
    .bus      (s_bus),
    .s0_dat_o (s0_dat_o),
    .s0_adr_o (s0_adr_o),
    .s0_sel_o (s0_sel_o),
    .s0_we_o  (s0_we_o),
    .s0_cyc_o (s0_cyc_o),
    .s0_stb_o (s0_stb_o),
    .s0_dat_i (s0_dat_i),
    .s0_ack_i (s0_ack_i),
    .s1_dat_o (s1_dat_o),
    .s1_adr_o (s1_adr_o),
    .s1_sel_o (s1_sel_o),
    .s1_we_o  (s1_we_o),
    .s1_cyc_o (s1_cyc_o),
    .s1_stb_o (s1_stb_o),
    .s1_dat_i (s1_dat_i),
    .s1_ack_i (s1_ack_i),
    .s2_dat_o (s2_dat_o),
    .s2_adr_o (s2_adr_o),
    .s2_sel_o (s2_sel_o),
    .s2_we_o  (s2_we_o),
    .s2_cyc_o (s2_cyc_o),
    .s2_stb_o (s2_stb_o),
    .s2_dat_i (s2_dat_i),
    .s2_ack_i (s2_ack_i)
  );

  // stage plus demux keep the slave strobes one-hot
  a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({s0_stb_o, s1_stb_o, s2_stb_o}))
    else $error("more than one slave strobed");

  // a master only gets a response while it is asking
  a_resp_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((mst_ack | mst_err) & ~mst_stb) == '0)
    else $error("response to an idle master");

endmodule

// File: src/wb_master_mux.sv
// module: granted master request select and response return to the owner
`timescale 1ns/1ps

module wb_master_mux #(
  parameter int NM = wb_ic_pkg::N_MST,
  parameter int DW = wb_ic_pkg::DATA_W,
  parameter int AW = wb_ic_pkg::ADR_W,
  parameter int SW = wb_ic_pkg::SEL_W
) (
  input  logic [NM-1:0][DW-1:0]       dat_i,
  input  logic [NM-1:0][AW-1:0]       adr_i,
  input  logic [NM-1:0][SW-1:0]       sel_i,
  input  logic [NM-1:0]               we_i,
  input  logic [NM-1:0]               cyc_i,
  input  logic [NM-1:0]               stb_i,
  input  wb_ic_pkg::target_e [NM-1:0] tid_i,
  input  wb_ic_pkg::arb_state_e       gnt_i,
  wb_req_if.mst                       bus,
  output logic [NM-1:0][DW-1:0]       rdat_o,
  output logic [NM-1:0]               ack_o,
  output logic [NM-1:0]               err_o
);
  import wb_ic_pkg::*;

  // request from the owner, word aligned
  assign bus.dat = dat_i[gnt_i];
  assign bus.adr = {adr_i[gnt_i][AW-1:2], 2'b00};
  assign bus.sel = sel_i[gnt_i];
  assign bus.we  = we_i[gnt_i];
  assign bus.cyc = cyc_i[gnt_i];
  assign bus.stb = stb_i[gnt_i];
  assign bus.tid = tid_i[gnt_i];

  // response goes to the owner only, others read zero
  always_comb begin
    for (int k = 0; k < NM; k++) begin
      if (int'(gnt_i) == k) begin
        rdat_o[k] = bus.rdat;
        ack_o[k]  = bus.ack;
        err_o[k]  = bus.err;
      end else begin
        rdat_o[k] = '0;
        ack_o[k]  = 1'b0;
        err_o[k]  = 1'b0;
      end
    end
  end

endmodule

// File: src/wb_req_if.sv
// interface: one wishbone request plus its response, master and slave modports
`timescale 1ns/1ps

interface wb_req_if #(
  parameter int DW = wb_ic_pkg::DATA_W,
  parameter int AW = wb_ic_pkg::ADR_W,
  parameter int SW = wb_ic_pkg::SEL_W
);
  import wb_ic_pkg::*;

  // request side
  logic [DW-1:0] dat;
  logic [AW-1:0] adr;
  logic [SW-1:0] sel;
  logic          we;
  logic          cyc;
  logic          stb;
  target_e       tid;

  // response side
  logic [DW-1:0] rdat;
  logic          ack;
  logic          err;

  modport mst (
    output dat, adr, sel, we, cyc, stb, tid,
    input  rdat, ack, err
  );

  modport slv (
    input  dat, adr, sel, we, cyc, stb, tid,
    output rdat, ack, err
  );

endinterface

// File: src/wb_rr_arbiter.sv
// module: round-robin bus owner FSM for the shared request path
`timescale 1ns/1ps

module wb_rr_arbiter #(
  parameter int NM = wb_ic_pkg::N_MST
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [NM-1:0]         req_i,
  input  logic                  busy_i,
  output wb_ic_pkg::arb_state_e gnt_o
);
  import wb_ic_pkg::*;

  arb_state_e state_q;
  arb_state_e state_d;

  // ------------------------------
  // next owner
  // hold while the stage works or the owner still requests
  always_comb begin
    state_d = state_q;
    if (!busy_i && !req_i[state_q]) begin
      case (state_q)
        OWN_M0: begin
          if (req_i[1]) begin
            state_d = OWN_M1;
          end else if (req_i[2]) begin
            state_d = OWN_M2;
          end
        end
        OWN_M1: begin
          if (req_i[2]) begin
            state_d = OWN_M2;
          end else if (req_i[0]) begin
            state_d = OWN_M0;
          end
        end
        OWN_M2: begin
          if (req_i[0]) begin
            state_d = OWN_M0;
          end else if (req_i[1]) begin
            state_d = OWN_M1;
          end
        end
        default: state_d = OWN_M0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= OWN_M0;
    end else begin
      state_q <= state_d;
    end
  end

  assign gnt_o = state_q;

  // owner must stay put while a transfer is in flight in the stage
  a_gnt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_i |=> $stable(gnt_o))
    else $error("grant moved while stage busy");

endmodule

// File: src/wb_slave_demux.sv
// module: staged request steering to one slave and slave response select
`timescale 1ns/1ps

module wb_slave_demux #(
  parameter int DW    = wb_ic_pkg::DATA_W,
  parameter int AW    = wb_ic_pkg::ADR_W,
  parameter int SW    = wb_ic_pkg::SEL_W,
  parameter int S1_AW = wb_ic_pkg::S1_ADR_W,
  parameter int S2_AW = wb_ic_pkg::S2_ADR_W
) (
  wb_req_if.slv         bus,
  // s0 flash and spi registers
  output logic [DW-1:0]    s0_dat_o,
  output logic [AW-1:0]    s0_adr_o,
  output logic [SW-1:0]    s0_sel_o,
  output logic             s0_we_o,
  output logic             s0_cyc_o,
  output logic             s0_stb_o,
  input  logic [DW-1:0]    s0_dat_i,
  input  logic             s0_ack_i,
  // s1 uart
  output logic [DW-1:0]    s1_dat_o,
  output logic [S1_AW-1:0] s1_adr_o,
  output logic [SW-1:0]    s1_sel_o,
  output logic             s1_we_o,
  output logic             s1_cyc_o,
  output logic             s1_stb_o,
  input  logic [DW-1:0]    s1_dat_i,
  input  logic             s1_ack_i,
  // s2 sram
  output logic [DW-1:0]    s2_dat_o,
  output logic [S2_AW-1:0] s2_adr_o,
  output logic [SW-1:0]    s2_sel_o,
  output logic             s2_we_o,
  output logic             s2_cyc_o,
  output logic             s2_stb_o,
  input  logic [DW-1:0]    s2_dat_i,
  input  logic             s2_ack_i
);
  import wb_ic_pkg::*;

  // ------------------------------
  // request steering
  // data, sel and we are shared, stb and cyc qualify them
  assign s0_dat_o = bus.dat;
  assign s0_adr_o = bus.adr;
  assign s0_sel_o = bus.sel;
  assign s0_we_o  = bus.we;
  assign s0_cyc_o = bus.cyc && (bus.tid == TGT_MEM);
  assign s0_stb_o = bus.stb && (bus.tid == TGT_MEM);

  // uart sees its 8 bit register offset
  assign s1_dat_o = bus.dat;
  assign s1_adr_o = bus.adr[S1_AW-1:0];
  assign s1_sel_o = bus.sel;
  assign s1_we_o  = bus.we;
  assign s1_cyc_o = bus.cyc && (bus.tid == TGT_UART);
  assign s1_stb_o = bus.stb && (bus.tid == TGT_UART);

  // sram sees 13 bits, remapped boot windows land in its low 8 KB
  assign s2_dat_o = bus.dat;
  assign s2_adr_o = bus.adr[S2_AW-1:0];
  assign s2_sel_o = bus.sel;
  assign s2_we_o  = bus.we;
  assign s2_cyc_o = bus.cyc && (bus.tid == TGT_SRAM);
  assign s2_stb_o = bus.stb && (bus.tid == TGT_SRAM);

  // ------------------------------
  // response select, ack only counts from a strobed slave
  always_comb begin
    case (bus.tid)
      TGT_MEM: begin
        bus.rdat = s0_dat_i;
        bus.ack  = s0_ack_i && bus.stb;
      end
      TGT_UART: begin
        bus.rdat = s1_dat_i;
        bus.ack  = s1_ack_i && bus.stb;
      end
      TGT_SRAM: begin
        bus.rdat = s2_dat_i;
        bus.ack  = s2_ack_i && bus.stb;
      end
      default: begin
        bus.rdat = '0;
        bus.ack  = 1'b0;
      end
    endcase
  end

  // targets have no error line
  assign bus.err = 1'b0;

endmodule

// File: src/wb_stage.sv
// module: staging registers between master and slave side, unmapped err reply
`timescale 1ns/1ps

module wb_stage #(
  parameter int DW = wb_ic_pkg::DATA_W,
  parameter int AW = wb_ic_pkg::ADR_W,
  parameter int SW = wb_ic_pkg::SEL_W
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  wb_req_if.slv m,
  wb_req_if.mst s,
  output logic  busy_o
);
  import wb_ic_pkg::*;

  // captured request
  logic [DW-1:0] dat_q;
  logic [AW-1:0] adr_q;
  logic [SW-1:0] sel_q;
  logic          we_q;
  target_e       tid_q;
  // control
  logic          s_stb_q;
  logic          ack_q;
  logic          err_q;
  logic [DW-1:0] rdat_q;
  logic          idle_w;
  logic          cap_w;

  // no capture in the response cycle, the master still holds stb there
  assign idle_w = !s_stb_q && !ack_q && !err_q;
  assign cap_w  = idle_w && m.stb && m.cyc;

  // ------------------------------
  // control path
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_stb_q <= 1'b0;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      // response strobes are single cycle
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (cap_w) begin
        // unmapped target never reaches a slave
        s_stb_q <= (m.tid != TGT_NONE);
        err_q   <= (m.tid == TGT_NONE);
      end else if (s_stb_q && (s.ack || s.err)) begin
        s_stb_q <= 1'b0;
        ack_q   <= s.ack && !s.err;
        err_q   <= s.err;
      end
    end
  end

  // payload path
  always_ff @(posedge clk_i) begin
    if (cap_w) begin
      dat_q <= m.dat;
      adr_q <= m.adr;
      sel_q <= m.sel;
      we_q  <= m.we;
      tid_q <= m.tid;
    end
    if (s_stb_q && s.ack) begin
      rdat_q <= s.rdat;
    end
  end

  // slave side
  assign s.dat = dat_q;
  assign s.adr = adr_q;
  assign s.sel = sel_q;
  assign s.we  = we_q;
  assign s.tid = tid_q;
  assign s.stb = s_stb_q;
  assign s.cyc = s_stb_q;

  // master side
  assign m.rdat = rdat_q;
  assign m.ack  = ack_q;
  assign m.err  = err_q;

  // low in the response cycle so the arbiter can rotate there
  assign busy_o = s_stb_q;

  // a strobed slave always carries a mapped target id
  a_none_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s.stb |-> (s.tid != TGT_NONE))
    else $error("unmapped request reached a slave");

  // one response per transfer, ack or err, one cycle wide
  a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m.ack || m.err) |-> !(m.ack && m.err) ##1 !(m.ack || m.err))
    else $error("bad response pulse on master side");

endmodule
